//--- src/ise_pkg.sv
package ise_pkg;

    // --------------------------------------------------
    // Widths and counts

    localparam int xlen       = 32;             // Data path width
    localparam int cpr_count  = 16;             // Number of coprocessor registers
    localparam int cpr_addr_w = 4;              // CPR address width
    localparam int gpr_addr_w = 5;              // GPR address width
    localparam int f3_w       = 3;              // funct3 field width

    // --------------------------------------------------
    // Encoding

    // Major opcode of the extension (custom-0), occupies bits 6..0
    localparam logic [6:0] ise_opcode = 7'b000_1011;

    // Field LSB positions inside the encoding
    localparam int fld_funct3 = 12;             // Bits 14..12
    localparam int fld_crd    = 7;              // Bits 10..7, CPR destination
    localparam int fld_rd     = 7;              // Bits 11..7, GPR destination
    localparam int fld_crs1   = 15;             // Bits 18..15
    localparam int fld_crs2   = 20;             // Bits 23..20
    localparam int fld_pw     = 25;             // Bits 26..25, pack width

    // funct3 codes, 3'b110 and 3'b111 are left unallocated
    localparam logic [f3_w-1:0] f3_mv2cop = 3'b000;
    localparam logic [f3_w-1:0] f3_mv2gpr = 3'b001;
    localparam logic [f3_w-1:0] f3_add_px = 3'b010;
    localparam logic [f3_w-1:0] f3_sub_px = 3'b011;
    localparam logic [f3_w-1:0] f3_cmov   = 3'b100;
    localparam logic [f3_w-1:0] f3_cmovn  = 3'b101;

    // --------------------------------------------------
    // Types

    typedef enum logic [2:0] {
        op_none,                                // No state change
        op_mv2cop,
        op_mv2gpr,
        op_add_px,
        op_sub_px,
        op_cmov,
        op_cmovn
    } ise_op_t;

    // Lane width of packed arithmetic
    typedef enum logic [1:0] {
        pw_32,
        pw_16,
        pw_8,
        pw_4
    } pack_width_t;

    typedef enum logic [2:0] {
        res_ok         = 3'd0,
        res_bad_opcode = 3'd1,
        res_bad_width  = 3'd2                   // Pack width switched off
    } ise_result_t;

endpackage

//--- src/ise_decode.sv
`timescale 1ns/1ps

module ise_decode #(
    parameter bit mccr_p32 = 1'b1,                  // 32-bit lanes enabled
    parameter bit mccr_p16 = 1'b1,
    parameter bit mccr_p8  = 1'b1,
    parameter bit mccr_p4  = 1'b1
) (
    input  logic                              cop_insn_valid,
    input  logic [ise_pkg::xlen-1:0]          cop_insn_enc,
    output ise_pkg::ise_op_t                  dec_op,
    output logic [ise_pkg::cpr_addr_w-1:0]    dec_crd,
    output logic [ise_pkg::cpr_addr_w-1:0]    dec_crs1,
    output logic [ise_pkg::cpr_addr_w-1:0]    dec_crs2,
    output logic [ise_pkg::gpr_addr_w-1:0]    dec_rd,
    output ise_pkg::pack_width_t              dec_pw,
    output logic                              dec_crs1_used,
    output logic                              dec_crs2_used,
    output ise_pkg::ise_result_t              dec_result
);

    import ise_pkg::*;

    logic [xlen-1:0] enc;                           // Encoding gated by valid
    logic [f3_w-1:0] funct3;
    ise_op_t         op_raw;                        // Before the width check
    logic            is_packed;
    logic            pw_en;                         // Enable of the selected width

    assign enc    = cop_insn_enc & {xlen{cop_insn_valid}};
    assign funct3 = enc[fld_funct3 +: f3_w];

    // Register fields are pulled out regardless of operation
    assign dec_crd  = enc[fld_crd  +: cpr_addr_w];
    assign dec_crs1 = enc[fld_crs1 +: cpr_addr_w];
    assign dec_crs2 = enc[fld_crs2 +: cpr_addr_w];
    assign dec_rd   = enc[fld_rd   +: gpr_addr_w];
    assign dec_pw   = pack_width_t'(enc[fld_pw +: $bits(pack_width_t)]);

    // --------------------------------------------------
    // Opcode and funct3 match

    always_comb
    begin
        op_raw = op_none;
        if (enc[$bits(ise_opcode)-1:0] == ise_opcode)
        begin
            case (funct3)
                f3_mv2cop: op_raw = op_mv2cop;
                f3_mv2gpr: op_raw = op_mv2gpr;
                f3_add_px: op_raw = op_add_px;
                f3_sub_px: op_raw = op_sub_px;
                f3_cmov:   op_raw = op_cmov;
                f3_cmovn:  op_raw = op_cmovn;
                default:   op_raw = op_none;    // Unallocated funct3
            endcase
        end
    end

    // Feature enable for the requested lane width
    always_comb
    begin
        case (dec_pw)
            pw_32:   pw_en = mccr_p32;
            pw_16:   pw_en = mccr_p16;
            pw_8:    pw_en = mccr_p8;
            default: pw_en = mccr_p4;
        endcase
    end

    assign is_packed = (op_raw == op_add_px) || (op_raw == op_sub_px);

    // --------------------------------------------------
    // Final operation, result code and source usage

    always_comb
    begin
        dec_op     = op_raw;
        dec_result = res_ok;
        if (op_raw == op_none)
        begin
            dec_result = res_bad_opcode;
        end
        else if (is_packed && !pw_en)
        begin
            dec_op     = op_none;               // Disabled width is a no-op
            dec_result = res_bad_width;
        end
    end

    // A rejected instruction reads nothing
    assign dec_crs1_used = (dec_op != op_none) && (dec_op != op_mv2cop);
    assign dec_crs2_used = (dec_op == op_add_px) || (dec_op == op_sub_px) ||
                           (dec_op == op_cmov)   || (dec_op == op_cmovn);

endmodule

//--- src/ise_cpr_file.sv
`timescale 1ns/1ps

module ise_cpr_file (
    input  logic                              g_clk,
    input  logic                              cpr_wen,
    input  logic [ise_pkg::cpr_addr_w-1:0]    cpr_waddr,
    input  logic [ise_pkg::xlen-1:0]          cpr_wdata,
    input  logic [ise_pkg::cpr_addr_w-1:0]    dec_crs1,
    input  logic [ise_pkg::cpr_addr_w-1:0]    dec_crs2,
    output logic [ise_pkg::xlen-1:0]          cpr_rdata1,
    output logic [ise_pkg::xlen-1:0]          cpr_rdata2
);

    import ise_pkg::*;

    // Coprocessor register array
    logic [xlen-1:0] cprs [cpr_count];

    always_ff @(posedge g_clk)
    begin
        if (cpr_wen)
        begin
            cprs[cpr_waddr] <= cpr_wdata;
        end
    end

    // Asynchronous reads, a write is seen the cycle after its edge
    assign cpr_rdata1 = cprs[dec_crs1];
    assign cpr_rdata2 = cprs[dec_crs2];

endmodule

//--- src/ise_packed_alu.sv
`timescale 1ns/1ps

module ise_packed_alu (
    input  logic                              cop_insn_valid,
    input  ise_pkg::ise_op_t                  dec_op,
    input  logic [ise_pkg::cpr_addr_w-1:0]    dec_crd,
    input  ise_pkg::pack_width_t              dec_pw,
    input  logic [ise_pkg::xlen-1:0]          cop_rs1,
    input  logic [ise_pkg::xlen-1:0]          cpr_rdata1,
    input  logic [ise_pkg::xlen-1:0]          cpr_rdata2,
    output logic                              cpr_wen,
    output logic [ise_pkg::cpr_addr_w-1:0]    cpr_waddr,
    output logic [ise_pkg::xlen-1:0]          cpr_wdata,
    output logic                              gpr_wen,
    output logic [ise_pkg::xlen-1:0]          gpr_wdata
);

    import ise_pkg::*;

    localparam int nibbles = xlen / 4;              // Smallest lane is 4 bits

    logic               is_sub;
    logic               cond;                       // crs2 non-zero
    logic [nibbles-1:0] lane_start;                 // Nibble opens a new lane
    logic [xlen-1:0]    opb;                        // Inverted for subtract
    logic [xlen-1:0]    packed_res;
    logic               carry;
    logic [4:0]         nib_sum;
    logic               wr_en;
    logic [xlen-1:0]    wr_data;
    logic               gpr_en;

    assign is_sub = (dec_op == op_sub_px);
    assign cond   = |cpr_rdata2;
    assign opb    = is_sub ? ~cpr_rdata2 : cpr_rdata2;

    // --------------------------------------------------
    // Packed add/sub as a nibble carry chain

    always_comb
    begin
        case (dec_pw)
            pw_32:   lane_start = nibbles'(1);
            pw_16:   lane_start = {(nibbles/4){4'b0001}};
            pw_8:    lane_start = {(nibbles/2){2'b01}};
            default: lane_start = {nibbles{1'b1}};
        endcase
    end

    always_comb
    begin
        carry = 1'b0;
        nib_sum = '0;
        for (int i = 0; i < nibbles; i++)
        begin
            if (lane_start[i])
                carry = is_sub;                     // Break chain, +1 for two's complement
            nib_sum = {1'b0, cpr_rdata1[4*i +: 4]} + {1'b0, opb[4*i +: 4]} + {4'b0, carry};
            packed_res[4*i +: 4] = nib_sum[3:0];
            carry = nib_sum[4];
        end
    end

    // --------------------------------------------------
    // Operation select

    always_comb
    begin
        wr_en   = 1'b0;
        wr_data = cpr_rdata1;                       // cmov/cmovn source
        gpr_en  = 1'b0;
        case (dec_op)
            op_mv2cop:
            begin
                wr_en   = 1'b1;
                wr_data = cop_rs1;
            end
            op_mv2gpr:            gpr_en = 1'b1;
            op_add_px, op_sub_px:
            begin
                wr_en   = 1'b1;
                wr_data = packed_res;
            end
            op_cmov:              wr_en = cond;
            op_cmovn:             wr_en = !cond;
            default:              wr_en = 1'b0;
        endcase
    end

    assign cpr_wen   = cop_insn_valid & wr_en;
    assign cpr_waddr = dec_crd;
    assign cpr_wdata = wr_data;
    assign gpr_wen   = cop_insn_valid & gpr_en;
    assign gpr_wdata = gpr_en ? cpr_rdata1 : '0;   // Zero unless mv2gpr

endmodule

//--- src/ise_result.sv
`timescale 1ns/1ps

module ise_result (
    input  logic                              g_clk,
    input  logic                              g_resetn,
    input  logic                              cop_insn_valid,
    input  ise_pkg::ise_result_t              dec_result,
    input  logic [ise_pkg::cpr_addr_w-1:0]    dec_crs1,
    input  logic [ise_pkg::cpr_addr_w-1:0]    dec_crs2,
    input  logic                              dec_crs1_used,
    input  logic                              dec_crs2_used,
    input  logic [ise_pkg::gpr_addr_w-1:0]    dec_rd,
    input  logic                              cpr_wen,
    input  logic [ise_pkg::cpr_addr_w-1:0]    cpr_waddr,
    input  logic                              gpr_wen,
    input  logic [ise_pkg::xlen-1:0]          gpr_wdata,
    output ise_pkg::ise_result_t              cop_result,
    output logic [ise_pkg::cpr_count-1:0]     cop_cprs_read,
    output logic [ise_pkg::cpr_count-1:0]     cop_cprs_written,
    output logic                              cop_rd_wen,
    output logic [ise_pkg::gpr_addr_w-1:0]    cop_rd_addr,
    output logic [ise_pkg::xlen-1:0]          cop_rd_data
);

    import ise_pkg::*;

    logic [cpr_count-1:0] rd_mask1;
    logic [cpr_count-1:0] rd_mask2;
    logic [cpr_count-1:0] wr_mask;

    // One-hot masks of CPRs touched
    assign rd_mask1 = dec_crs1_used ? (cpr_count'(1) << dec_crs1) : '0;
    assign rd_mask2 = dec_crs2_used ? (cpr_count'(1) << dec_crs2) : '0;
    assign wr_mask  = cpr_wen       ? (cpr_count'(1) << cpr_waddr) : '0;

    // --------------------------------------------------
    // Outputs hold until the next valid instruction

    always_ff @(posedge g_clk)
    begin
        if (!g_resetn)
        begin
            cop_result       <= res_ok;
            cop_cprs_read    <= '0;
            cop_cprs_written <= '0;
            cop_rd_wen       <= 1'b0;
            cop_rd_addr      <= '0;
            cop_rd_data      <= '0;
        end
        else if (cop_insn_valid)
        begin
            // Every field is rewritten so nothing carries over
            cop_result       <= dec_result;
            cop_cprs_read    <= rd_mask1 | rd_mask2;
            cop_cprs_written <= wr_mask;
            cop_rd_wen       <= gpr_wen;
            cop_rd_addr      <= gpr_wen ? dec_rd : '0;
            cop_rd_data      <= gpr_wdata;          // Already zero without write-back
        end
    end

endmodule

//--- src/ise_top.sv
`timescale 1ns/1ps

module ise_top #(
    parameter bit mccr_p32 = 1'b1,                  // Pack width feature enables
    parameter bit mccr_p16 = 1'b1,
    parameter bit mccr_p8  = 1'b1,
    parameter bit mccr_p4  = 1'b1
) (
    input  logic                              g_clk,
    input  logic                              g_resetn,
    input  logic                              cop_insn_valid,   // One-cycle strobe
    input  logic [ise_pkg::xlen-1:0]          cop_insn_enc,
    input  logic [ise_pkg::xlen-1:0]          cop_rs1,          // GPR source value
    output ise_pkg::ise_result_t              cop_result,
    output logic [ise_pkg::cpr_count-1:0]     cop_cprs_read,
    output logic [ise_pkg::cpr_count-1:0]     cop_cprs_written,
    output logic                              cop_rd_wen,
    output logic [ise_pkg::gpr_addr_w-1:0]    cop_rd_addr,
    output logic [ise_pkg::xlen-1:0]          cop_rd_data
);

    import ise_pkg::*;

    // --------------------------------------------------
    // Decode outputs

    ise_op_t               dec_op;
    logic [cpr_addr_w-1:0] dec_crd;
    logic [cpr_addr_w-1:0] dec_crs1;
    logic [cpr_addr_w-1:0] dec_crs2;
    logic [gpr_addr_w-1:0] dec_rd;
    pack_width_t           dec_pw;
    logic                  dec_crs1_used;
    logic                  dec_crs2_used;
    ise_result_t           dec_result;

    // Register file and execute
    logic [xlen-1:0]       cpr_rdata1;
    logic [xlen-1:0]       cpr_rdata2;
    logic                  cpr_wen;
    logic [cpr_addr_w-1:0] cpr_waddr;
    logic [xlen-1:0]       cpr_wdata;
    logic                  gpr_wen;
    logic [xlen-1:0]       gpr_wdata;

    ise_decode #(
        .mccr_p32 (mccr_p32),
        .mccr_p16 (mccr_p16),
        .mccr_p8  (mccr_p8),
        .mccr_p4  (mccr_p4)
    ) u_decode (
        .cop_insn_valid (cop_insn_valid),
        .cop_insn_enc   (cop_insn_enc),
        .dec_op         (dec_op),
        .dec_crd        (dec_crd),
        .dec_crs1       (dec_crs1),
        .dec_crs2       (dec_crs2),
        .dec_rd         (dec_rd),
        .dec_pw         (dec_pw),
        .dec_crs1_used  (dec_crs1_used),
        .dec_crs2_used  (dec_crs2_used),
        .dec_result     (dec_result)
    );

    ise_cpr_file u_cpr_file (
        .g_clk      (g_clk),
        .cpr_wen    (cpr_wen),
        .cpr_waddr  (cpr_waddr),
        .cpr_wdata  (cpr_wdata),
        .dec_crs1   (dec_crs1),
        .dec_crs2   (dec_crs2),
        .cpr_rdata1 (cpr_rdata1),
        .cpr_rdata2 (cpr_rdata2)
    );

    ise_packed_alu u_alu (
        .cop_insn_valid (cop_insn_valid),
        .dec_op         (dec_op),
        .dec_crd        (dec_crd),
        .dec_pw         (dec_pw),
        .cop_rs1        (cop_rs1),
        .cpr_rdata1     (cpr_rdata1),
        .cpr_rdata2     (cpr_rdata2),
        .cpr_wen        (cpr_wen),
        .cpr_waddr      (cpr_waddr),
        .cpr_wdata      (cpr_wdata),
        .gpr_wen        (gpr_wen),
        .gpr_wdata      (gpr_wdata)
    );

    // Registered reporting, one cycle after the strobe
    ise_result u_result (
        .g_clk            (g_clk),
        .g_resetn         (g_resetn),
        .cop_insn_valid   (cop_insn_valid),
        .dec_result       (dec_result),
        .dec_crs1         (dec_crs1),
        .dec_crs2         (dec_crs2),
        .dec_crs1_used    (dec_crs1_used),
        .dec_crs2_used    (dec_crs2_used),
        .dec_rd           (dec_rd),
        .cpr_wen          (cpr_wen),
        .cpr_waddr        (cpr_waddr),
        .gpr_wen          (gpr_wen),
        .gpr_wdata        (gpr_wdata),
        .cop_result       (cop_result),
        .cop_cprs_read    (cop_cprs_read),
        .cop_cprs_written (cop_cprs_written),
        .cop_rd_wen       (cop_rd_wen),
        .cop_rd_addr      (cop_rd_addr),
        .cop_rd_data      (cop_rd_data)
    );

endmodule

//--- dv/ise_props.sv
`timescale 1ns/1ps

module ise_props (
    input  logic                              g_clk,
    input  logic                              g_resetn,
    input  ise_pkg::ise_result_t              cop_result,
    input  logic [ise_pkg::cpr_count-1:0]     cop_cprs_written,
    input  logic                              cop_rd_wen
);

    import ise_pkg::*;

    int fail_cnt = 0;                               // Read by the testbench top

    // Synchronous reset clears the write-back strobe
    a_rst_rd_wen: assert property (@(posedge g_clk) !g_resetn |=> !cop_rd_wen)
    else
    begin
        $error("rd_wen high one cycle after reset");
        fail_cnt++;
    end

    // Write-back only for a successful instruction
    a_wen_ok: assert property (@(posedge g_clk) disable iff (!g_resetn)
        cop_rd_wen |-> (cop_result == res_ok))
    else
    begin
        $error("rd_wen high with a failing result code");
        fail_cnt++;
    end

    // At most one CPR written, and none on a rejected instruction
    a_wmask: assert property (@(posedge g_clk) disable iff (!g_resetn)
        $onehot0(cop_cprs_written) && (cop_result == res_ok || cop_cprs_written == '0))
    else
    begin
        $error("written mask not one-hot or set on a failing result");
        fail_cnt++;
    end

endmodule

//--- dv/ise_checker.sv
`timescale 1ns/1ps

module ise_checker (
    input  logic                              g_clk,
    input  logic                              chk_valid,
    input  int                                chk_idx,
    input  logic [31:0]                       exp_result,
    input  logic [31:0]                       exp_rmask,
    input  logic [31:0]                       exp_wmask,
    input  logic [31:0]                       exp_rd_wen,
    input  logic [31:0]                       exp_rd_addr,
    input  logic [31:0]                       exp_rd_data,
    input  ise_pkg::ise_result_t              cop_result,
    input  logic [ise_pkg::cpr_count-1:0]     cop_cprs_read,
    input  logic [ise_pkg::cpr_count-1:0]     cop_cprs_written,
    input  logic                              cop_rd_wen,
    input  logic [ise_pkg::gpr_addr_w-1:0]    cop_rd_addr,
    input  logic [ise_pkg::xlen-1:0]          cop_rd_data,
    output int                                pass_count,
    output int                                fail_count
);

    int n_pass = 0;
    int n_fail = 0;
    bit mismatch;                                   // Set by any field of the current test

    assign pass_count = n_pass;
    assign fail_count = n_fail;

    // --------------------------------------------------
    // Field compare

    task automatic compare_field(input string name, input logic [31:0] got,
                                 input logic [31:0] want, input int idx);
        if (got !== want)
        begin
            $display("[ERROR] %0t: test %0d %s is %h, expected %h",
                     $time, idx, name, got, want);
            mismatch = 1'b1;
        end
    endtask

    // Outputs of the previous strobe, read before this edge loads the next one
    always @(posedge g_clk)
    begin
        if (chk_valid)
        begin
            mismatch = 1'b0;
            compare_field("result",       32'(cop_result),       exp_result,  chk_idx);
            compare_field("cprs_read",    32'(cop_cprs_read),    exp_rmask,   chk_idx);
            compare_field("cprs_written", 32'(cop_cprs_written), exp_wmask,   chk_idx);
            compare_field("rd_wen",       32'(cop_rd_wen),       exp_rd_wen,  chk_idx);
            compare_field("rd_addr",      32'(cop_rd_addr),      exp_rd_addr, chk_idx);
            compare_field("rd_data",      32'(cop_rd_data),      exp_rd_data, chk_idx);
            if (mismatch)
            begin
                n_fail++;
                $display("test %0d failed", chk_idx);
            end
            else
            begin
                n_pass++;
                $display("test %0d passed", chk_idx);
            end
        end
    end

endmodule

//--- dv/tb_ise.sv
`timescale 1ns/1ps

module tb_ise;

    import ise_pkg::*;

    localparam int n_vec   = 60;                    // Lines in the stim file
    localparam int n_col   = 9;                     // Words per line
    localparam int mem_aw  = $clog2(n_vec * n_col);
    localparam int rst_cyc = 10;
    localparam int max_cyc = 4 * n_vec + rst_cyc + 50;

    logic                  g_clk;
    logic                  g_resetn;
    logic                  cop_insn_valid;
    logic [xlen-1:0]       cop_insn_enc;
    logic [xlen-1:0]       cop_rs1;
    ise_result_t           cop_result;
    logic [cpr_count-1:0]  cop_cprs_read;
    logic [cpr_count-1:0]  cop_cprs_written;
    logic                  cop_rd_wen;
    logic [gpr_addr_w-1:0] cop_rd_addr;
    logic [xlen-1:0]       cop_rd_data;

    // --------------------------------------------------
    // Expected values toward the checker

    logic                  chk_valid;               // One cycle after the strobe
    int                    chk_idx;
    logic [31:0]           exp_result;
    logic [31:0]           exp_rmask;
    logic [31:0]           exp_wmask;
    logic [31:0]           exp_rd_wen;
    logic [31:0]           exp_rd_addr;
    logic [31:0]           exp_rd_data;
    int                    pass_count;
    int                    fail_count;

    logic [31:0]           vec_mem [n_vec*n_col];   // Flat copy of the stim file
    int                    cycles = 0;
    bit                    stim_ok;

    ise_top u_dut (
        .g_clk            (g_clk),
        .g_resetn         (g_resetn),
        .cop_insn_valid   (cop_insn_valid),
        .cop_insn_enc     (cop_insn_enc),
        .cop_rs1          (cop_rs1),
        .cop_result       (cop_result),
        .cop_cprs_read    (cop_cprs_read),
        .cop_cprs_written (cop_cprs_written),
        .cop_rd_wen       (cop_rd_wen),
        .cop_rd_addr      (cop_rd_addr),
        .cop_rd_data      (cop_rd_data)
    );

    ise_checker u_checker (
        .g_clk            (g_clk),
        .chk_valid        (chk_valid),
        .chk_idx          (chk_idx),
        .exp_result       (exp_result),
        .exp_rmask        (exp_rmask),
        .exp_wmask        (exp_wmask),
        .exp_rd_wen       (exp_rd_wen),
        .exp_rd_addr      (exp_rd_addr),
        .exp_rd_data      (exp_rd_data),
        .cop_result       (cop_result),
        .cop_cprs_read    (cop_cprs_read),
        .cop_cprs_written (cop_cprs_written),
        .cop_rd_wen       (cop_rd_wen),
        .cop_rd_addr      (cop_rd_addr),
        .cop_rd_data      (cop_rd_data),
        .pass_count       (pass_count),
        .fail_count       (fail_count)
    );

    bind ise_top ise_props u_props (
        .g_clk            (g_clk),
        .g_resetn         (g_resetn),
        .cop_result       (cop_result),
        .cop_cprs_written (cop_cprs_written),
        .cop_rd_wen       (cop_rd_wen)
    );

    always #5 g_clk = ~g_clk;                       // 10 ns period

    // --------------------------------------------------
    // Stim file access

    function automatic logic [31:0] stim_word(input int idx, input int col);
        stim_word = vec_mem[mem_aw'(idx * n_col + col)];
    endfunction

    task automatic load_stim();
        for (int i = 0; i < n_vec * n_col; i++)
            vec_mem[mem_aw'(i)] = 32'hf111_0000 ^ 32'(i);   // Marks words the file leaves out
        $readmemh("dv/ise_stim.txt", vec_mem);
        stim_ok = (stim_word(n_vec - 1, n_col - 1) !=
                   (32'hf111_0000 ^ 32'(n_vec * n_col - 1)));
        if (!stim_ok)
            $display("Stim file dv/ise_stim.txt holds fewer lines than expected");
    endtask

    task automatic drive_vector(input int idx);
        cop_insn_valid = 1'b1;
        cop_insn_enc   = stim_word(idx, 0);
        cop_rs1        = stim_word(idx, 1);
    endtask

    // Hands the expected outputs of one line to the checker, idx < 0 means none
    task automatic post_expected(input int idx);
        if (idx < 0)
        begin
            chk_valid = 1'b0;
        end
        else
        begin
            chk_idx     = idx;
            exp_result  = stim_word(idx, 2);
            exp_rmask   = stim_word(idx, 3);
            exp_wmask   = stim_word(idx, 4);
            exp_rd_wen  = stim_word(idx, 5);
            exp_rd_addr = stim_word(idx, 6);
            exp_rd_data = stim_word(idx, 7);
            chk_valid   = 1'b1;
        end
    endtask

    // --------------------------------------------------
    // Main sequence

    initial
    begin
        int pend;                                   // Line whose outputs are due next
        pend           = -1;
        g_clk          = 1'b0;
        g_resetn       = 1'b0;
        cop_insn_valid = 1'b0;
        cop_insn_enc   = '0;
        cop_rs1        = '0;
        chk_valid      = 1'b0;
        chk_idx        = 0;
        exp_result     = '0;
        exp_rmask      = '0;
        exp_wmask      = '0;
        exp_rd_wen     = '0;
        exp_rd_addr    = '0;
        exp_rd_data    = '0;
        load_stim();
        repeat (rst_cyc) @(negedge g_clk);
        g_resetn = 1'b1;
        for (int i = 0; i < n_vec; i++)
        begin
            @(negedge g_clk);
            drive_vector(i);
            post_expected(pend);                    // Previous line, if back-to-back
            pend = i;
            if (stim_word(i, 8) != 32'd0)           // Gap column asks for an idle cycle
            begin
                @(negedge g_clk);
                cop_insn_valid = 1'b0;
                post_expected(pend);
                pend = -1;
            end
        end
        @(negedge g_clk);
        cop_insn_valid = 1'b0;
        post_expected(pend);
        @(negedge g_clk);
        post_expected(-1);
        @(negedge g_clk);
        $display("Summary: %0d passed, %0d failed, %0d assertion failures",
                 pass_count, fail_count, u_dut.u_props.fail_cnt);
        if (stim_ok && fail_count == 0 && pass_count == n_vec && u_dut.u_props.fail_cnt == 0)
        begin
            $display("RESULT: PASS");
        end
        else
        begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

    // Run limit in clock cycles
    always @(posedge g_clk)
    begin
        cycles <= cycles + 1;
        if (cycles >= max_cyc)
        begin
            $display("Timeout: test did not finish within %0d cycles", max_cyc);
            $display("RESULT: FAIL");
            $finish;
        end
    end

endmodule

//--- dv/ise_stim.txt
// enc rs1 result read_mask written_mask rd_wen rd_addr rd_data gap
// gap 1 adds an idle cycle after the line, gap 0 drives the next line at once
// mv2cop into every CPR, back to back
0000000b 00000000 0 0000 0001 0 00 00000000 0
0000008b 12345678 0 0000 0002 0 00 00000000 0
0000010b 9abcdef0 0 0000 0004 0 00 00000000 0
0000018b ffffffff 0 0000 0008 0 00 00000000 0
0000020b 00000001 0 0000 0010 0 00 00000000 0
0000028b 0badc0de 0 0000 0020 0 00 00000000 0
0000030b 5a5a5a5a 0 0000 0040 0 00 00000000 0
0000038b a5a5a5a5 0 0000 0080 0 00 00000000 0
0000040b deadbeef 0 0000 0100 0 00 00000000 0
0000048b cafef00d 0 0000 0200 0 00 00000000 0
0000050b 01234567 0 0000 0400 0 00 00000000 0
0000058b 76543210 0 0000 0800 0 00 00000000 0
0000060b fedcba98 0 0000 1000 0 00 00000000 0
0000068b 13579bdf 0 0000 2000 0 00 00000000 0
0000070b 2468ace0 0 0000 4000 0 00 00000000 0
0000078b 80000001 0 0000 8000 0 00 00000000 0
// mv2gpr of every CPR, the first one right after its write
00079c8b 00000000 0 8000 0000 1 19 80000001 1
0000150b 00000000 0 0001 0000 1 0a 00000000 1
0000958b 00000000 0 0002 0000 1 0b 12345678 1
0001160b 00000000 0 0004 0000 1 0c 9abcdef0 1
0001968b 00000000 0 0008 0000 1 0d ffffffff 1
0002170b 00000000 0 0010 0000 1 0e 00000001 1
0002978b 00000000 0 0020 0000 1 0f 0badc0de 1
0003180b 00000000 0 0040 0000 1 10 5a5a5a5a 1
0003988b 00000000 0 0080 0000 1 11 a5a5a5a5 1
0004190b 00000000 0 0100 0000 1 12 deadbeef 1
0004998b 00000000 0 0200 0000 1 13 cafef00d 1
00051a0b 00000000 0 0400 0000 1 14 01234567 1
00059a8b 00000000 0 0800 0000 1 15 76543210 1
00061b0b 00000000 0 1000 0000 1 16 fedcba98 1
00069b8b 00000000 0 2000 0000 1 17 13579bdf 1
00071c0b 00000000 0 4000 0000 1 18 2468ace0 1
// Packed add/sub, each result read back in the next cycle
0020a38b 00000000 0 0006 0080 0 00 00000000 0
0003908b 00000000 0 0080 0000 1 01 acf13568 1
0220a40b 00000000 0 0006 0100 0 00 00000000 0
0004110b 00000000 0 0100 0000 1 02 acf03568 1
0420a48b 00000000 0 0006 0200 0 00 00000000 0
0004918b 00000000 0 0200 0000 1 03 acf03468 1
0620a50b 00000000 0 0006 0400 0 00 00000000 0
0005120b 00000000 0 0400 0000 1 04 ace02468 1
0020b58b 00000000 0 0006 0800 0 00 00000000 0
0005928b 00000000 0 0800 0000 1 05 77777788 1
0620b60b 00000000 0 0006 1000 0 00 00000000 0
0006130b 00000000 0 1000 0000 1 06 88888888 1
0241a68b 00000000 0 0018 2000 0 00 00000000 0
0006938b 00000000 0 2000 0000 1 07 ffff0000 1
0440370b 00000000 0 0011 4000 0 00 00000000 0
0007140b 00000000 0 4000 0000 1 08 000000ff 1
// cmov and cmovn, taken and not taken
0012c30b 00000000 0 0022 0040 0 00 00000000 0
0003148b 00000000 0 0040 0000 1 09 0badc0de 1
0001478b 00000000 0 0005 0000 0 00 00000000 0
00079f8b 00000000 0 8000 0000 1 1f 80000001 1
0001578b 00000000 0 0005 8000 0 00 00000000 0
00079f8b 00000000 0 8000 0000 1 1f 9abcdef0 1
0030d30b 00000000 0 000a 0000 0 00 00000000 0
0003148b 00000000 0 0040 0000 1 09 0badc0de 1
// Unallocated funct3, foreign opcode, then CPR 1 unchanged
0000608b ffffffff 1 0000 0000 0 00 00000000 1
0000708b ffffffff 1 0000 0000 0 00 00000000 1
000000b3 deadbeef 1 0000 0000 0 00 00000000 1
00009f0b 00000000 0 0002 0000 1 1e 12345678 1

//--- flist.f
src/ise_pkg.sv
src/ise_decode.sv
src/ise_cpr_file.sv
src/ise_packed_alu.sv
src/ise_result.sv
src/ise_top.sv
dv/ise_props.sv
dv/ise_checker.sv
dv/tb_ise.sv

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" && \
verilator --binary --top-module tb_ise -f flist.f -Mdir obj_dir && \
./obj_dir/Vtb_ise | tee /dev/stderr | grep "RESULT: PASS" > /dev/null || exit 1
